// File: flist.f
logic/spi_regs_pkg.sv
logic/spi_slave.sv
logic/byte_fifo.sv
logic/cmd_engine.sv
logic/spi_reg_top.sv
bench/tb_spi_reg_top.sv

// File: Makefile
# Verilator build and run of the SPI register block testbench.
# Example: make test CPOL=1 CPHA=1 LOG=mode3.log

VERILATOR ?= verilator
CPOL      ?= 0
CPHA      ?= 0
LOG       ?= sim.log
OBJ_DIR   ?= obj_dir
FLIST     ?= flist.f
VFLAGS    ?= --binary --assert --timescale 1ns/100ps -j 0

TOP       := tb_spi_reg_top
FAIL_MSG  := Test failures found
PASS_MSG  := All tests passed

.PHONY: help test clean

help:
	@echo "make test   build and run the testbench (CPOL=$(CPOL) CPHA=$(CPHA)), log in $(LOG)"
	@echo "make clean  remove $(OBJ_DIR) and $(LOG)"
	@echo "make help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) \
		-GCPOL=$(CPOL) -GCPHA=$(CPHA) -f $(FLIST)
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then \
		echo "simulation reported failures, see $(LOG)"; exit 1; \
	fi
	@if ! grep -q "$(PASS_MSG)" $(LOG); then \
		echo "simulation ended without a result, see $(LOG)"; exit 1; \
	fi
	@echo "simulation passed"

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// File: bench/tb_spi_reg_top.sv
// Testbench for the SPI register block in the SPI mode given by CPOL/CPHA.
// A master task sends command frames; a register model predicts the byte that
// every frame returns on miso, and assertions compare the two.

`default_nettype none

module tb_spi_reg_top
	import spi_regs_pkg::*;
#(
	parameter bit CPOL = 1'b0,
	parameter bit CPHA = 1'b0
);

	timeunit 1ns;
	timeprecision 100ps;

	localparam int HALF       = 8;	// sys_clk cycles per sclk half period
	localparam int GAP        = 24;	// cs high between frames
	localparam int FRAME_OVH  = 2 * HALF + GAP;
	localparam int BYTE_CYC   = 16 * HALF;
	localparam int RUN_FRAMES = 83;
	localparam int RUN_BYTES  = 115;	// aborted tail counted as a whole byte
	localparam int LIMIT = 3 * (RUN_FRAMES * FRAME_OVH + RUN_BYTES * BYTE_CYC + 8) / 2;

	logic              sys_clk;
	logic              sys_rst_n;
	logic              cs;
	logic              sclk;
	logic              mosi;
	logic              miso;
	logic              overflow;

	logic [DATA_W-1:0] model [REG_COUNT];	// expected register file
	logic [DATA_W-1:0] exp_reply;	// returned by every byte of the next frame
	logic [DATA_W-1:0] frame_buf [5];
	logic [15:0]       lfsr = 16'd20430;
	int                cycle_cnt = 0;
	int                errors = 0;
	int                ovf_errors = 0;
	int                checks = 0;
	int                tests_run = 0;
	int                tests_failed = 0;
	int                test_errs0;
	string             test_name;

	spi_reg_top #(
		.CPOL (CPOL),
		.CPHA (CPHA)
	) dut_i (
		.sys_clk   (sys_clk),
		.sys_rst_n (sys_rst_n),
		.cs        (cs),
		.sclk      (sclk),
		.mosi      (mosi),
		.miso      (miso),
		.overflow  (overflow)
	);

	initial begin
		sys_clk = 1'b0;
		forever #20 sys_clk = ~sys_clk;
	end

	// run limit at 1.5x the summed frame lengths
	always @(posedge sys_clk) begin
		cycle_cnt <= cycle_cnt + 1;
		if (cycle_cnt == LIMIT) begin
			$display("timeout: run stopped after %0d sys_clk cycles", cycle_cnt);
			$display("Test failures found");
			$finish;
		end
	end

	// engine drains faster than bytes arrive
	always @(posedge sys_clk) begin
		if (sys_rst_n) begin
			assert (overflow === 1'b0) else begin
				$display("[ERROR] time %0d ns: overflow expected 0, got %b", $time, overflow);
				errors++;
				ovf_errors++;
			end
		end
	end

	// taps x^16 + x^14 + x^13 + x^11 + 1 stepped once per bit
	function automatic logic [7:0] rand_bits(input int n);
		logic [7:0] val;
		logic       fb;
		val = '0;
		for (int i = 0; i < n; i++) begin
			fb   = lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10];
			lfsr = {lfsr[14:0], fb};
			val  = {val[6:0], fb};
		end
		return val;
	endfunction

	function automatic logic [DATA_W-1:0] cmd_byte(input opcode_t op, input logic [3:0] addr);
		logic [7:0] junk;
		junk = rand_bits(2);	// bits 5:4 are don't-care
		return {op, junk[1:0], addr};
	endfunction

	task automatic check_byte(input string what, input logic [7:0] exp, input logic [7:0] act);
		checks++;
		assert (act === exp) else begin
			$display("[ERROR] time %0d ns: %s expected 0x%02h, got 0x%02h", $time, what, exp, act);
			errors++;
		end
	endtask

	task automatic test_begin(input string name);
		test_name  = name;
		test_errs0 = errors;
		tests_run++;
	endtask

	task automatic test_end();
		if (errors == test_errs0) begin
			$display("test %0d %s: ok", tests_run, test_name);
		end else begin
			tests_failed++;
			$display("test %0d %s: FAILED, %0d errors", tests_run, test_name,
				errors - test_errs0);
		end
	endtask

	// msb first with miso sampled at the start of the second half of each bit
	task automatic shift_bits(input logic [7:0] tx, input int nbits, output logic [7:0] rx);
		rx = '0;
		for (int i = 7; i >= 8 - nbits; i--) begin
			@(posedge sys_clk);
			sclk <= CPHA ? ~CPOL : CPOL;	// leading edge in cpha 1, trailing in cpha 0
			mosi <= tx[i];
			repeat (HALF - 1) @(posedge sys_clk);
			@(posedge sys_clk);
			rx[i] = miso;
			sclk <= CPHA ? CPOL : ~CPOL;
			repeat (HALF - 1) @(posedge sys_clk);
		end
	endtask

	// apply the complete commands of the last frame to the model
	task automatic update_model(input int nbytes);
		opcode_t    op;
		logic [3:0] addr;
		int         i;
		i = 0;
		while (i < nbytes) begin
			op   = opcode_t'(frame_buf[i][7:6]);
			addr = frame_buf[i][3:0];
			if (op == OP_WRITE || op == OP_ADD) begin
				if (i + 1 < nbytes) begin	// data byte must have arrived
					if (op == OP_WRITE)
						model[addr] = frame_buf[i + 1];
					else
						model[addr] = model[addr] + frame_buf[i + 1];
				end
				i += 2;
			end else begin
				if (op == OP_READ)
					exp_reply = model[addr];
				i += 1;
			end
		end
	endtask

	// nbytes whole bytes from frame_buf, then tail_bits of the next one
	task automatic send_frame(input int nbytes, input int tail_bits);
		logic [7:0] rx;
		@(posedge sys_clk);
		cs <= 1'b0;
		repeat (HALF - 1) @(posedge sys_clk);
		for (int b = 0; b < nbytes; b++) begin
			shift_bits(frame_buf[b], 8, rx);
			check_byte("miso", exp_reply, rx);
		end
		if (tail_bits > 0)
			shift_bits(frame_buf[nbytes], tail_bits, rx);
		@(posedge sys_clk);
		sclk <= CPOL;
		repeat (HALF - 1) @(posedge sys_clk);
		@(posedge sys_clk);
		cs   <= 1'b1;
		mosi <= 1'b0;
		repeat (GAP - 1) @(posedge sys_clk);
		update_model(nbytes);
	endtask

	task automatic send_cmd(input logic [7:0] cmd);
		frame_buf[0] = cmd;
		send_frame(1, 0);
	endtask

	task automatic send_cmd_data(input logic [7:0] cmd, input logic [7:0] data);
		frame_buf[0] = cmd;
		frame_buf[1] = data;
		send_frame(2, 0);
	endtask

	task automatic read_all();
		for (int a = 0; a < REG_COUNT; a++)
			send_cmd(cmd_byte(OP_READ, 4'(a)));
		send_cmd(cmd_byte(OP_NOP, 4'd0));	// collects the last reply
	endtask

	initial begin
		logic [3:0] addr;
		logic [7:0] data;
		sys_rst_n = 1'b0;
		cs        = 1'b1;
		sclk      = CPOL;
		mosi      = 1'b0;
		for (int i = 0; i < REG_COUNT; i++)
			model[i] = '0;
		exp_reply = '0;
		repeat (4) @(posedge sys_clk);
		sys_rst_n <= 1'b1;

		test_begin("reads after reset return zero");
		read_all();
		test_end();

		test_begin("random writes read back");
		for (int i = 0; i < 16; i++) begin
			addr = 4'(rand_bits(4));
			data = rand_bits(8);
			send_cmd_data(cmd_byte(OP_WRITE, addr), data);
		end
		read_all();
		test_end();

		test_begin("add accumulates modulo 256");
		addr = 4'(rand_bits(4));
		for (int i = 0; i < 8; i++) begin
			data = rand_bits(8);
			send_cmd_data(cmd_byte(OP_ADD, addr), data);
		end
		send_cmd(cmd_byte(OP_READ, addr));
		send_cmd(cmd_byte(OP_NOP, addr));
		test_end();

		test_begin("same reply in every byte, nop changes nothing");
		addr = 4'(rand_bits(4));
		send_cmd_data(cmd_byte(OP_WRITE, addr), ~exp_reply);	// new reply differs from the old
		frame_buf[0] = cmd_byte(OP_READ, addr);
		for (int i = 1; i < 4; i++)
			frame_buf[i] = cmd_byte(OP_NOP, 4'(rand_bits(4)));
		send_frame(4, 0);	// reply changes mid-frame while miso keeps the old byte
		for (int i = 0; i < 4; i++)
			frame_buf[i] = cmd_byte(OP_NOP, 4'(rand_bits(4)));
		send_frame(4, 0);
		read_all();
		test_end();

		test_begin("aborted write leaves register unchanged");
		addr = 4'(rand_bits(4));
		frame_buf[0] = cmd_byte(OP_WRITE, addr);
		frame_buf[1] = ~model[addr];	// visible if it were taken
		send_frame(1, 3);
		send_cmd(cmd_byte(OP_READ, addr));
		send_cmd(cmd_byte(OP_NOP, addr));
		test_end();

		test_begin("overflow stays low");
		check_byte("overflow", 8'h00, {7'd0, overflow});
		assert (ovf_errors == 0) else begin
			$display("overflow was raised during the run");
			errors++;
		end
		test_end();

		$display("%0d tests, %0d failed, %0d checks, %0d errors",
			tests_run, tests_failed, checks, errors);
		if (errors == 0)
			$display("All tests passed!");
		else
			$display("Test failures found");
		$finish;
	end

endmodule

`default_nettype wire

// File: logic/spi_reg_top.sv
// Top level of the SPI register block.
// SPI slave feeds a byte FIFO that the command engine drains; reads come back on miso.

`default_nettype none

module spi_reg_top
	import spi_regs_pkg::*;
#(
	parameter bit CPOL = 1'b0,
	parameter bit CPHA = 1'b0
)
(
	input  wire  sys_clk,
	input  wire  sys_rst_n,

	input  wire  cs,
	input  wire  sclk,
	input  wire  mosi,
	output logic miso,

	output logic overflow	// fifo dropped a byte
);

	logic              rx_valid;
	logic [DATA_W-1:0] rx_byte;
	logic              rx_first;
	logic              fifo_empty;
	logic [DATA_W-1:0] fifo_byte;
	logic              fifo_first;
	logic              fifo_rd;
	logic [DATA_W-1:0] reply;

	spi_slave #(
		.CPOL (CPOL),
		.CPHA (CPHA)
	) slave_i (
		.sys_clk   (sys_clk),
		.sys_rst_n (sys_rst_n),
		.cs        (cs),
		.sclk      (sclk),
		.mosi      (mosi),
		.miso      (miso),
		.reply     (reply),
		.rx_valid  (rx_valid),
		.rx_byte   (rx_byte),
		.rx_first  (rx_first)
	);

	byte_fifo fifo_i (
		.sys_clk   (sys_clk),
		.sys_rst_n (sys_rst_n),
		.wr        (rx_valid),
		.wr_byte   (rx_byte),
		.wr_first  (rx_first),
		.rd        (fifo_rd),
		.empty     (fifo_empty),
		.rd_byte   (fifo_byte),
		.rd_first  (fifo_first),
		.overflow  (overflow)
	);

	cmd_engine engine_i (
		.sys_clk    (sys_clk),
		.sys_rst_n  (sys_rst_n),
		.fifo_empty (fifo_empty),
		.fifo_byte  (fifo_byte),
		.fifo_first (fifo_first),
		.fifo_rd    (fifo_rd),
		.reply      (reply)
	);

endmodule

`default_nettype wire

// File: logic/cmd_engine.sv
// Command engine: pops bytes from the FIFO, parses one- and two-byte commands
// and applies them to a file of sixteen 8-bit registers.
// A read loads the reply register that the slave returns in the next frame.

`default_nettype none

module cmd_engine
	import spi_regs_pkg::*;
(
	input  wire               sys_clk,
	input  wire               sys_rst_n,

	input  wire               fifo_empty,
	input  wire  [DATA_W-1:0] fifo_byte,
	input  wire               fifo_first,	// byte opened a frame
	output logic              fifo_rd,	// single-cycle pop

	output logic [DATA_W-1:0] reply
);

	parse_state_t      state;
	opcode_t           byte_op;
	opcode_t           op;
	logic [ADDR_W-1:0] addr;
	logic [DATA_W-1:0] data;
	logic [DATA_W-1:0] regs [REG_COUNT];
	logic              pop_d;
	logic              take_cmd;

	// never pop two cycles in a row
	assign fifo_rd = ~fifo_empty & ~pop_d;

	assign byte_op  = opcode_t'(fifo_byte[DATA_W-1 -: 2]);
	assign take_cmd = fifo_first | (state != PS_DATA);	// frame start always resyncs

	always_ff @(posedge sys_clk) begin
		if (!sys_rst_n) begin
			state <= PS_CMD;
			pop_d <= 1'b0;
		end else begin
			pop_d <= fifo_rd;
			if (fifo_rd) begin
				if (take_cmd) begin
					case (byte_op)
						OP_WRITE, OP_ADD: state <= PS_DATA;
						OP_READ:          state <= PS_EXEC;
						default:          state <= PS_CMD;	// nop, nothing to do
					endcase
				end else begin
					state <= PS_EXEC;	// data byte arrived
				end
			end else if (state == PS_EXEC) begin
				state <= PS_CMD;
			end
		end
	end

	// command fields
	always_ff @(posedge sys_clk) begin
		if (fifo_rd) begin
			if (take_cmd) begin
				op   <= byte_op;
				addr <= fifo_byte[ADDR_W-1:0];	// bits 5:4 ignored
			end else begin
				data <= fifo_byte;
			end
		end
	end

	// register file and reply
	always_ff @(posedge sys_clk) begin
		if (!sys_rst_n) begin
			for (int i = 0; i < REG_COUNT; i++) begin
				regs[i] <= '0;
			end
			reply <= '0;
		end else if (state == PS_EXEC) begin
			case (op)
				OP_WRITE: regs[addr] <= data;
				OP_ADD:   regs[addr] <= regs[addr] + data;	// mod 256
				OP_READ:  reply      <= regs[addr];
				default:  ;
			endcase
		end
	end

	a_state_legal: assert property (@(posedge sys_clk) disable iff (!sys_rst_n)
		state inside {PS_CMD, PS_DATA, PS_EXEC});

endmodule

`default_nettype wire

// File: logic/byte_fifo.sv
// Small synchronous FIFO between the SPI slave and the command engine.
// Each entry carries a byte and its start-of-frame flag. Writes to a full
// FIFO are dropped and raise a sticky overflow flag.

`default_nettype none

module byte_fifo
	import spi_regs_pkg::*;
(
	input  wire               sys_clk,
	input  wire               sys_rst_n,

	input  wire               wr,
	input  wire  [DATA_W-1:0] wr_byte,
	input  wire               wr_first,
	input  wire               rd,	// pop, only when not empty

	output logic              empty,
	output logic [DATA_W-1:0] rd_byte,
	output logic              rd_first,
	output logic              overflow	// sticky until reset
);

	logic [DATA_W:0]    mem [FIFO_DEPTH];	// {first, byte}
	logic [FIFO_AW-1:0] wr_ptr;
	logic [FIFO_AW-1:0] rd_ptr;
	logic [FIFO_AW:0]   count;
	logic               full;
	logic               do_wr;
	logic               do_rd;

	assign empty = (count == '0);
	assign full  = (count == (FIFO_AW+1)'(FIFO_DEPTH));
	assign do_wr = wr & ~full;
	assign do_rd = rd & ~empty;

	always_ff @(posedge sys_clk) begin
		if (do_wr)
			mem[wr_ptr] <= {wr_first, wr_byte};
	end

	always_ff @(posedge sys_clk) begin
		if (!sys_rst_n) begin
			wr_ptr   <= '0;
			rd_ptr   <= '0;
			count    <= '0;
			overflow <= 1'b0;
		end else begin
			if (do_wr)
				wr_ptr <= wr_ptr + 1'b1;	// natural wrap, depth is a power of two
			if (do_rd)
				rd_ptr <= rd_ptr + 1'b1;
			case ({do_wr, do_rd})
				2'b10:   count <= count + 1'b1;
				2'b01:   count <= count - 1'b1;
				default: count <= count;
			endcase
			if (wr && full)
				overflow <= 1'b1;	// byte lost
		end
	end

	// head of queue, follows rd_ptr
	assign rd_byte  = mem[rd_ptr][DATA_W-1:0];
	assign rd_first = mem[rd_ptr][DATA_W];

	a_no_pop_empty: assert property (@(posedge sys_clk) disable iff (!sys_rst_n)
		rd |-> !empty);

endmodule

`default_nettype wire

// File: logic/spi_slave.sv
// SPI slave bit engine running on sys_clk.
// Pins are synchronized and edge detected; CPOL/CPHA select the sample and launch edges.
// Each received byte is strobed out with a start-of-frame flag, and the reply byte
// is shifted out on miso for every byte of a frame.

`default_nettype none

module spi_slave
	import spi_regs_pkg::*;
#(
	parameter bit CPOL = 1'b0,	// sclk idle level
	parameter bit CPHA = 1'b0	// 0: sample on leading edge, 1: on trailing edge
)
(
	input  wire               sys_clk,
	input  wire               sys_rst_n,

	input  wire               cs,	// chip select, active low
	input  wire               sclk,
	input  wire               mosi,
	output logic              miso,

	input  wire  [DATA_W-1:0] reply,	// byte returned in every frame
	output logic              rx_valid,	// one cycle per received byte
	output logic [DATA_W-1:0] rx_byte,
	output logic              rx_first	// first byte after cs fell
);

	slave_state_t                 state;
	logic [SYNC_STAGES-1:0]       cs_sync;
	logic [SYNC_STAGES-1:0]       sclk_sync;
	logic [SYNC_STAGES-1:0]       mosi_sync;
	logic                         cs_prev;
	logic                         sclk_prev;
	logic                         cs_s;
	logic                         sclk_s;
	logic                         mosi_s;
	logic                         cs_fall;
	logic                         sclk_rise;
	logic                         sclk_fall;
	logic                         lead_edge;
	logic                         trail_edge;
	logic                         sample_edge;
	logic                         launch_edge;
	logic [$clog2(DATA_W)-1:0]    bit_cnt;
	logic                         first_pend;
	logic [DATA_W-1:0]            rx_shift;
	logic [DATA_W-1:0]            tx_shift;
	logic [DATA_W-1:0]            tx_copy;

	// pin synchronizers, idle levels on reset so no false edge is seen
	always_ff @(posedge sys_clk) begin
		if (!sys_rst_n) begin
			cs_sync   <= '1;
			sclk_sync <= {SYNC_STAGES{CPOL}};
			cs_prev   <= 1'b1;
			sclk_prev <= CPOL;
		end else begin
			cs_sync   <= {cs_sync[SYNC_STAGES-2:0], cs};
			sclk_sync <= {sclk_sync[SYNC_STAGES-2:0], sclk};
			cs_prev   <= cs_s;
			sclk_prev <= sclk_s;
		end
	end

	always_ff @(posedge sys_clk) begin
		mosi_sync <= {mosi_sync[SYNC_STAGES-2:0], mosi};	// aligned with sclk
	end

	assign cs_s   = cs_sync[SYNC_STAGES-1];
	assign sclk_s = sclk_sync[SYNC_STAGES-1];
	assign mosi_s = mosi_sync[SYNC_STAGES-1];

	assign cs_fall   = cs_prev & ~cs_s;
	assign sclk_rise = ~sclk_prev & sclk_s;
	assign sclk_fall = sclk_prev & ~sclk_s;

	// leading edge leaves the idle level
	assign lead_edge   = CPOL ? sclk_fall : sclk_rise;
	assign trail_edge  = CPOL ? sclk_rise : sclk_fall;
	assign sample_edge = ~cs_s & (CPHA ? trail_edge : lead_edge);
	assign launch_edge = ~cs_s & (CPHA ? lead_edge : trail_edge);

	always_ff @(posedge sys_clk) begin
		if (!sys_rst_n) begin
			state      <= ST_IDLE;
			bit_cnt    <= '0;
			first_pend <= 1'b0;
			rx_valid   <= 1'b0;
			rx_first   <= 1'b0;
		end else begin
			rx_valid <= 1'b0;
			if (cs_s) begin	// deselect drops any partial byte
				state   <= ST_IDLE;
				bit_cnt <= '0;
			end else begin
				case (state)
					ST_IDLE: begin
						if (cs_fall) begin
							state      <= ST_SHIFT;
							bit_cnt    <= '0;
							first_pend <= 1'b1;
						end
					end
					ST_SHIFT: begin
						if (sample_edge) begin
							bit_cnt <= bit_cnt + 1'b1;	// wraps to zero after the last bit
							if (&bit_cnt)
								state <= ST_BYTE_DONE;
						end
					end
					ST_BYTE_DONE: begin
						rx_valid   <= 1'b1;
						rx_first   <= first_pend;
						first_pend <= 1'b0;
						state      <= ST_SHIFT;
					end
					default: state <= ST_IDLE;
				endcase
			end
		end
	end

	always_ff @(posedge sys_clk) begin
		if (state == ST_SHIFT && sample_edge)
			rx_shift <= {rx_shift[DATA_W-2:0], mosi_s};	// msb first
		if (state == ST_BYTE_DONE)
			rx_byte <= rx_shift;
		if (cs_fall)
			tx_copy <= reply;	// held for the whole frame
	end

	// transmit shifter, reloaded from the frame copy at each byte start
	always_ff @(posedge sys_clk) begin
		if (!sys_rst_n)
			tx_shift <= '0;
		else if (cs_fall)
			tx_shift <= reply;
		else if (launch_edge) begin
			if (bit_cnt == '0)
				tx_shift <= tx_copy;
			else
				tx_shift <= {tx_shift[DATA_W-2:0], 1'b0};
		end
	end

	assign miso = tx_shift[DATA_W-1];

	a_rx_valid_single: assert property (@(posedge sys_clk) disable iff (!sys_rst_n)
		rx_valid |=> !rx_valid);

endmodule

`default_nettype wire

// File: logic/spi_regs_pkg.sv
// Shared constants and enumerations for the SPI register block.
// Import with a wildcard in the module header of every block that needs them.

`default_nettype none

package spi_regs_pkg;

	localparam int DATA_W      = 8;	// spi byte and register width
	localparam int ADDR_W      = 4;	// register address bits
	localparam int REG_COUNT   = 16;	// size of the register file
	localparam int FIFO_DEPTH  = 8;	// entries between slave and engine
	localparam int FIFO_AW     = 3;	// fifo pointer width
	localparam int SYNC_STAGES = 2;	// flops on each pin synchronizer

	// command opcode, bits 7:6 of a command byte
	typedef enum logic [1:0] {
		OP_NOP   = 2'b00,
		OP_WRITE = 2'b01,	// followed by a data byte
		OP_READ  = 2'b10,
		OP_ADD   = 2'b11	// followed by a data byte
	} opcode_t;

	// spi slave bit engine
	typedef enum logic [1:0] {
		ST_IDLE      = 2'b00,	// cs high
		ST_SHIFT     = 2'b01,	// collecting bits
		ST_BYTE_DONE = 2'b10	// strobe the byte out
	} slave_state_t;

	// command parser
	typedef enum logic [1:0] {
		PS_CMD  = 2'b00,	// expecting a command byte
		PS_DATA = 2'b01,	// expecting the data byte
		PS_EXEC = 2'b10	// apply the command
	} parse_state_t;

endpackage

`default_nettype wire
